/* src/floatFormatPkg.sv */
////////////////////
// single-precision float format: field widths, special values
// and the word type read both raw and as fields
////////////////////
package floatFormatPkg;

    localparam int expWidth  = 8;
    localparam int fracWidth = 23;
    // hidden bit plus stored fraction
    localparam int sigWidth  = fracWidth + 1;

    // exponent of infinity and NaN
    localparam logic [expWidth-1:0]  expMax  = '1;
    localparam logic [fracWidth-1:0] nanFrac = '1;

    typedef struct packed {
        logic                 sign;
        logic [expWidth-1:0]  exponent;
        logic [fracWidth-1:0] fraction;
    } floatFields_t;

    // same 32 bits, seen whole or split into fields
    typedef union packed {
        logic [31:0]  raw;
        floatFields_t fields;
    } floatWord_t;

endpackage

/* src/addPathPkg.sv */
////////////////////
// widths of the adder's internal significand datapath
////////////////////
package addPathPkg;

    // guard, round and sticky
    localparam int guardBits = 3;

    // significand with the three extra bits below it
    localparam int workWidth = floatFormatPkg::sigWidth + guardBits;

    // enough to count up to workWidth - 1 leading zeros
    localparam int lzcWidth  = 5;

endpackage

/* src/floatUnpack.sv */
`timescale 1ns/1ns
////////////////////
// splits both operands into fields and flags NaN and infinity
////////////////////
module floatUnpack
    import floatFormatPkg::*;
(
    input  floatWord_t          a,
    input  floatWord_t          b,
    output logic                signA,
    output logic                signB,
    output logic [expWidth-1:0] expA,
    output logic [expWidth-1:0] expB,
    output logic [sigWidth-1:0] sigA,
    output logic [sigWidth-1:0] sigB,
    output logic                nan,
    output logic                infA,
    output logic                infB
);
    logic maxExpA;
    logic maxExpB;
    logic fracZeroA;
    logic fracZeroB;

    assign signA = a.fields.sign;
    assign signB = b.fields.sign;
    assign expA  = a.fields.exponent;
    assign expB  = b.fields.exponent;

    // zero exponent reads as zero, denormals included
    assign sigA = (expA == '0) ? '0 : {1'b1, a.fields.fraction};
    assign sigB = (expB == '0) ? '0 : {1'b1, b.fields.fraction};

    assign maxExpA   = (expA == expMax);
    assign maxExpB   = (expB == expMax);
    assign fracZeroA = (a.fields.fraction == '0);
    assign fracZeroB = (b.fields.fraction == '0);

    assign nan  = (maxExpA && !fracZeroA) || (maxExpB && !fracZeroB);
    assign infA = maxExpA && fracZeroA;
    assign infB = maxExpB && fracZeroB;

endmodule

/* src/alignOperands.sv */
`timescale 1ns/1ns
////////////////////
// orders the operands by magnitude and shifts the smaller one right,
// folding the bits shifted out into a sticky bit
////////////////////
module alignOperands
    import floatFormatPkg::*;
    import addPathPkg::*;
(
    input  logic                 signA,
    input  logic                 signB,
    input  logic [expWidth-1:0]  expA,
    input  logic [expWidth-1:0]  expB,
    input  logic [sigWidth-1:0]  sigA,
    input  logic [sigWidth-1:0]  sigB,
    output logic [expWidth-1:0]  expAlign,
    output logic [workWidth-1:0] numX,
    output logic [workWidth-1:0] numY,
    output logic                 signX,
    output logic                 signY
);
    logic                 aFirst;
    logic [expWidth-1:0]  expSmall;
    logic [expWidth-1:0]  shiftAmount;
    logic [lzcWidth-1:0]  shiftLow;
    logic                 bigShift;
    logic [workWidth-1:0] numYTemp;
    logic [workWidth-1:0] numYShift;
    logic [workWidth-1:0] lostBits;
    logic                 stickyBit;

    // a is X when its exponent wins, or on a tie when its significand is not smaller
    assign aFirst = (expA > expB) || ((expA == expB) && (sigA >= sigB));

    assign expAlign = aFirst ? expA : expB;
    assign expSmall = aFirst ? expB : expA;
    assign signX    = aFirst ? signA : signB;
    assign signY    = aFirst ? signB : signA;

    assign numX     = aFirst ? {sigA, {guardBits{1'b0}}} : {sigB, {guardBits{1'b0}}};
    assign numYTemp = aFirst ? {sigB, {guardBits{1'b0}}} : {sigA, {guardBits{1'b0}}};

    assign shiftAmount = expAlign - expSmall;
    assign shiftLow    = shiftAmount[lzcWidth-1:0];
    // 32 and up clears Y
    assign bigShift    = |shiftAmount[expWidth-1:lzcWidth];

    assign numYShift = bigShift ? '0 : (numYTemp >> shiftLow);

    // everything that falls off the right end
    assign lostBits  = numYTemp & ~({workWidth{1'b1}} << shiftLow);
    assign stickyBit = bigShift ? |numYTemp : |lostBits;

    // low bit keeps its own value in the sticky as well
    assign numY = {numYShift[workWidth-1:1], numYShift[0] | stickyBit};

endmodule

/* src/sumNormalize.sv */
`timescale 1ns/1ns
////////////////////
// adds or subtracts the aligned magnitudes, then normalizes
// the sum and corrects its exponent
////////////////////
module sumNormalize
    import floatFormatPkg::*;
    import addPathPkg::*;
(
    input  logic [expWidth-1:0]  expAlign,
    input  logic [workWidth-1:0] numX,
    input  logic [workWidth-1:0] numY,
    input  logic                 signX,
    input  logic                 signY,
    output logic [expWidth-1:0]  expNorm,
    output logic [workWidth-1:0] sumNorm,
    output logic                 zero,
    output logic                 underflow,
    output logic                 normOverflow
);
    logic                 sameSign;
    logic [workWidth:0]   rawSum;
    logic [workWidth-1:0] sum;
    logic                 carry;
    logic [lzcWidth-1:0]  lead0;
    logic [workWidth-1:0] sumLShift;
    logic [expWidth-1:0]  expOne;
    logic [expWidth:0]    expDiff;

    assign sameSign = (signX == signY);

    // X is never smaller than Y, so the difference cannot go negative
    assign rawSum = sameSign ? ({1'b0, numX} + {1'b0, numY})
                             : ({1'b0, numX} - {1'b0, numY});
    assign sum    = rawSum[workWidth-1:0];
    assign carry  = sameSign && rawSum[workWidth];

    assign zero = !sameSign && (numX == numY);

    // leading-zero count, highest set bit wins
    always_comb begin
        lead0 = '0;
        for (int i = 0; i < workWidth; i++) begin
            if (sum[i]) begin
                lead0 = lzcWidth'(workWidth - 1 - i);
            end
        end
    end

    assign sumLShift = sum << lead0;

    assign expOne  = expAlign + 1'b1;
    assign expDiff = {1'b0, expAlign} - (expWidth + 1)'(lead0);

    always_comb begin
        if (carry) begin
            // one bit right, the two lowest bits merge into sticky
            sumNorm = {1'b1, sum[workWidth-1:2], sum[1] | sum[0]};
            expNorm = expOne;
        end else begin
            sumNorm = sumLShift;
            expNorm = expDiff[expWidth-1:0];
        end
    end

    assign normOverflow = carry && (expOne == expMax);

    // borrow, or an exponent landing on zero, has no normal encoding
    assign underflow = !carry && (expDiff[expWidth] || (expDiff[expWidth-1:0] == '0));

endmodule

/* src/realRounding.sv */
`timescale 1ns/1ns
////////////////////
// round to nearest even on the normalized sum
////////////////////
module realRounding
    import floatFormatPkg::*;
    import addPathPkg::*;
(
    input  logic [expWidth-1:0]  expNorm,
    input  logic [workWidth-1:0] sumNorm,
    output logic [expWidth-1:0]  expRound,
    output logic [sigWidth-1:0]  sigRound,
    output logic                 roundOverflow
);
    logic                guardBit;
    logic                roundBit;
    logic                stickyBit;
    logic                keptLsb;
    logic                roundUp;
    logic [sigWidth:0]   roundAdd;
    logic                rOut;
    logic [expWidth-1:0] expAdd;

    assign guardBit  = sumNorm[2];
    assign roundBit  = sumNorm[1];
    assign stickyBit = sumNorm[0];
    assign keptLsb   = sumNorm[guardBits];

    // above half, or exactly half with an odd kept value
    assign roundUp = guardBit && (roundBit || stickyBit || keptLsb);

    assign roundAdd = {1'b0, sumNorm[workWidth-1:guardBits]} + {{sigWidth{1'b0}}, roundUp};
    assign rOut     = roundAdd[sigWidth];

    assign expAdd = expNorm + 1'b1;

    // carry out means the significand wrapped to 1.000
    assign sigRound = rOut ? roundAdd[sigWidth:1] : roundAdd[sigWidth-1:0];
    assign expRound = rOut ? expAdd : expNorm;

    assign roundOverflow = rOut && (expAdd == expMax);

endmodule

/* src/resultAdjust.sv */
`timescale 1ns/1ns
////////////////////
// picks the final word: NaN, infinity, zero or the rounded sum
////////////////////
module resultAdjust
    import floatFormatPkg::*;
(
    input  logic                underflow,
    input  logic                roundOverflow,
    input  logic                normOverflow,
    input  logic                zero,
    input  logic                nan,
    input  logic                infA,
    input  logic                infB,
    input  logic                signX,
    input  logic                signY,
    input  logic [expWidth-1:0] expRound,
    input  logic [sigWidth-1:0] sigRound,
    output floatWord_t          result
);
    logic nanRes;
    logic infRes;
    logic zeroRes;

    // inf - inf is invalid
    assign nanRes  = nan || (infA && infB && (signX != signY));
    assign infRes  = roundOverflow || normOverflow || infA || infB;
    assign zeroRes = underflow || zero;

    always_comb begin
        result.raw = '0;
        if (nanRes) begin
            result.fields.sign     = signX;
            result.fields.exponent = expMax;
            result.fields.fraction = nanFrac;
        end else if (infRes) begin
            result.fields.sign     = signX;
            result.fields.exponent = expMax;
        end else if (!zeroRes) begin
            result.fields.sign     = signX;
            result.fields.exponent = expRound;
            result.fields.fraction = sigRound[fracWidth-1:0];
        end
    end

endmodule

/* src/floatAdder.sv */
`timescale 1ns/1ns
////////////////////
// pipelined single-precision adder; inValid strobes an operand pair
// and outValid strobes its sum two clock edges later
////////////////////
module floatAdder
    import floatFormatPkg::*;
    import addPathPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       inValid,
    input  floatWord_t a,
    input  floatWord_t b,
    output logic       outValid,
    output floatWord_t result
);
    logic                 signA;
    logic                 signB;
    logic [expWidth-1:0]  expA;
    logic [expWidth-1:0]  expB;
    logic [sigWidth-1:0]  sigA;
    logic [sigWidth-1:0]  sigB;
    logic                 nan;
    logic                 infA;
    logic                 infB;

    logic [expWidth-1:0]  expAlign;
    logic [workWidth-1:0] numX;
    logic [workWidth-1:0] numY;
    logic                 signX;
    logic                 signY;

    // stage 1
    logic                 s1Valid;
    logic [expWidth-1:0]  s1ExpAlign;
    logic [workWidth-1:0] s1NumX;
    logic [workWidth-1:0] s1NumY;
    logic                 s1SignX;
    logic                 s1SignY;
    logic                 s1Nan;
    logic                 s1InfA;
    logic                 s1InfB;

    logic [expWidth-1:0]  expNorm;
    logic [workWidth-1:0] sumNorm;
    logic                 zero;
    logic                 underflow;
    logic                 normOverflow;
    logic [expWidth-1:0]  expRound;
    logic [sigWidth-1:0]  sigRound;
    logic                 roundOverflow;
    floatWord_t           adjWord;

    floatUnpack unpack (
        .a     (a),
        .b     (b),
        .signA (signA),
        .signB (signB),
        .expA  (expA),
        .expB  (expB),
        .sigA  (sigA),
        .sigB  (sigB),
        .nan   (nan),
        .infA  (infA),
        .infB  (infB)
    );

    alignOperands align (
        .signA    (signA),
        .signB    (signB),
        .expA     (expA),
        .expB     (expB),
        .sigA     (sigA),
        .sigB     (sigB),
        .expAlign (expAlign),
        .numX     (numX),
        .numY     (numY),
        .signX    (signX),
        .signY    (signY)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid  <= 1'b0;
            outValid <= 1'b0;
        end else begin
            s1Valid  <= inValid;
            outValid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            s1ExpAlign <= expAlign;
            s1NumX     <= numX;
            s1NumY     <= numY;
            s1SignX    <= signX;
            s1SignY    <= signY;
            s1Nan      <= nan;
            s1InfA     <= infA;
            s1InfB     <= infB;
        end
        if (s1Valid) begin
            result <= adjWord;
        end
    end

    sumNormalize normalize (
        .expAlign     (s1ExpAlign),
        .numX         (s1NumX),
        .numY         (s1NumY),
        .signX        (s1SignX),
        .signY        (s1SignY),
        .expNorm      (expNorm),
        .sumNorm      (sumNorm),
        .zero         (zero),
        .underflow    (underflow),
        .normOverflow (normOverflow)
    );

    realRounding rounding (
        .expNorm       (expNorm),
        .sumNorm       (sumNorm),
        .expRound      (expRound),
        .sigRound      (sigRound),
        .roundOverflow (roundOverflow)
    );

    resultAdjust adjust (
        .underflow     (underflow),
        .roundOverflow (roundOverflow),
        .normOverflow  (normOverflow),
        .zero          (zero),
        .nan           (s1Nan),
        .infA          (s1InfA),
        .infB          (s1InfB),
        .signX         (s1SignX),
        .signY         (s1SignY),
        .expRound      (expRound),
        .sigRound      (sigRound),
        .result        (adjWord)
    );

endmodule

/* include/floatAddModel.svh */
////////////////////
// reference model of the adder for the testbench
// call expectedSum with two raw float words
////////////////////
`ifndef FLOAT_ADD_MODEL_SVH
`define FLOAT_ADD_MODEL_SVH

function automatic logic isNanWord(input logic [31:0] w);
    return (w[30:23] == 8'hFF) && (w[22:0] != 23'd0);
endfunction

function automatic logic isInfWord(input logic [31:0] w);
    return (w[30:23] == 8'hFF) && (w[22:0] == 23'd0);
endfunction

// widen to double; a zero exponent reads as zero
function automatic real floatToReal(input logic [31:0] w);
    logic [63:0] d;
    d = {w[31], 11'(w[30:23]) + 11'd896, w[22:0], 29'd0};
    if (w[30:23] == 8'd0) begin
        d = 64'd0;
    end
    return $bitstoreal(d);
endfunction

// narrow with round to nearest even, flush below normal to +0
function automatic logic [31:0] realToFloat(input real r);
    logic [63:0] d;
    int          e;
    logic [23:0] m;
    d = $realtobits(r);
    e = int'(d[62:52]) - 896;
    m = {1'b0, d[51:29]};
    if (d[28] && ((d[27:0] != 28'd0) || d[29])) begin
        m = m + 24'd1;
    end
    if (m[23]) begin
        e = e + 1;
    end
    if (e < 1) begin
        return 32'd0;
    end
    if (e >= 255) begin
        return {d[63], 8'hFF, 23'd0};
    end
    return {d[63], 8'(e), m[22:0]};
endfunction

// NaN sign is left at zero here
function automatic logic [31:0] expectedSum(input logic [31:0] a, input logic [31:0] b);
    if (isNanWord(a) || isNanWord(b) || (isInfWord(a) && isInfWord(b) && (a[31] != b[31]))) begin
        return {1'b0, 8'hFF, 23'h7FFFFF};
    end
    if (isInfWord(a)) begin
        return a;
    end
    if (isInfWord(b)) begin
        return b;
    end
    return realToFloat(floatToReal(a) + floatToReal(b));
endfunction

`endif

/* testbench/floatAdderTb.sv */
`timescale 1ns/1ns
////////////////////
// testbench for floatAdder: directed and random pairs,
// in-order result checks and outValid timing checks
////////////////////
module floatAdderTb
    import floatFormatPkg::*;
    import addPathPkg::*;
;
    `include "floatAddModel.svh"

    localparam int numDirected = 17;
    localparam int numRandom   = 200;
    localparam int numGap      = 40;
    localparam int numSpaced   = 5;
    localparam int numBurst    = 20;
    localparam int numVectors  = numDirected + numRandom + numGap + numSpaced + numBurst;
    localparam int timeoutNs   = (numVectors + 20) * 8;

    logic       clk = 1'b0;
    logic       rst;
    logic       inValid;
    floatWord_t a;
    floatWord_t b;
    logic       outValid;
    floatWord_t result;

    logic [31:0] lfsrState = 32'h2560;
    logic [31:0] expQueue[$];
    string       nameQueue[$];
    logic [1:0]  validPipe = 2'b00;
    int          checks = 0;
    int          errors = 0;

    floatAdder DUT (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .a        (a),
        .b        (b),
        .outValid (outValid),
        .result   (result)
    );

    always #4 clk = ~clk;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // normal operands, exponent gap 0..24, far from overflow and underflow
    task automatic randomNormalPair(output logic [31:0] x, output logic [31:0] y);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] f;
        int          expX;
        int          gap;
        takeBits(8, r);
        expX = 50 + int'(r[7:0]) % 151;
        takeBits(5, r);
        gap = int'(r[4:0]) % 25;
        takeBits(2, s);
        takeBits(23, f);
        x = {s[0], 8'(expX), f[22:0]};
        takeBits(23, f);
        y = {s[1], 8'(expX - gap), f[22:0]};
    endtask

    // gap of 26 or more, x is always the larger magnitude
    task automatic largeGapPair(output logic [31:0] x, output logic [31:0] y);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] f;
        int          expX;
        int          gap;
        takeBits(7, r);
        expX = 100 + int'(r[6:0]) % 100;
        takeBits(5, r);
        gap = 26 + int'(r[4:0]) % 20;
        takeBits(2, s);
        takeBits(23, f);
        x = {s[0], 8'(expX), f[22:0]};
        takeBits(23, f);
        y = {s[1], 8'(expX - gap), f[22:0]};
    endtask

    task automatic applyPair(input logic [31:0] x, input logic [31:0] y,
                             input logic [31:0] want, input string testName);
        @(posedge clk);
        #1;
        a.raw   = x;
        b.raw   = y;
        inValid = 1'b1;
        expQueue.push_back(want);
        nameQueue.push_back(testName);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
        end
    endtask

    task automatic runDirected();
        applyPair(32'h3FC00000, 32'hBFC00000, 32'h00000000, "zeroCancel");
        applyPair(32'h40490FDB, 32'hC0490FDB, 32'h00000000, "zeroCancel");
        applyPair(32'h00000000, 32'h40490FDB, 32'h40490FDB, "zeroOperand");
        applyPair(32'h00012345, 32'hC0200000, 32'hC0200000, "denormAsZero");
        applyPair(32'h00800001, 32'h80800000, expectedSum(32'h00800001, 32'h80800000), "underflow");
        applyPair(32'h00C00000, 32'h80800000, expectedSum(32'h00C00000, 32'h80800000), "underflow");
        applyPair(32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000, "overflow");
        applyPair(32'hFF7FFFFF, 32'hFF000000, 32'hFF800000, "overflow");
        applyPair(32'h7F800000, 32'h3F800000, 32'h7F800000, "infFinite");
        applyPair(32'h40000000, 32'hFF800000, 32'hFF800000, "infFinite");
        applyPair(32'h7F800000, 32'h7F800000, 32'h7F800000, "infSameSign");
        applyPair(32'hFF800000, 32'hFF800000, 32'hFF800000, "infSameSign");
        applyPair(32'h7F800000, 32'hFF800000, expectedSum(32'h7F800000, 32'hFF800000), "infMinusInf");
        applyPair(32'h7FC00000, 32'h3F800000, expectedSum(32'h7FC00000, 32'h3F800000), "nanOperand");
        applyPair(32'h3F800000, 32'hFFA00001, expectedSum(32'h3F800000, 32'hFFA00001), "nanOperand");
        // ties go to the even neighbour
        applyPair(32'h3F800000, 32'h33800000, 32'h3F800000, "roundEven");
        applyPair(32'h3F800001, 32'h33800000, 32'h3F800002, "roundEven");
    endtask

    // expected outValid, two edges behind inValid
    always @(posedge clk) begin
        if (rst) begin
            validPipe <= 2'b00;
        end else begin
            validPipe <= {validPipe[0], inValid};
        end
    end

    always @(negedge clk) begin
        logic [31:0] want;
        logic [31:0] got;
        string       testName;
        logic        match;
        checks++;
        assert (outValid == validPipe[1]) else begin
            $display("** Error timing: expected outValid %b, actual %b", validPipe[1], outValid);
            errors++;
        end
        if (outValid) begin
            if (expQueue.size() == 0) begin
                $display("result strobed with no pair waiting for it");
                errors++;
            end else begin
                want     = expQueue.pop_front();
                testName = nameQueue.pop_front();
                got      = result.raw;
                // sign of a NaN is free
                match    = isNanWord(want) ? (got[30:0] == want[30:0]) : (got == want);
                checks++;
                assert (match) else begin
                    $display("** Error %s: expected %h, actual %h", testName, want, got);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(timeoutNs);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [31:0] x;
        logic [31:0] y;
        rst     = 1'b1;
        inValid = 1'b0;
        a.raw   = '0;
        b.raw   = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        runDirected();
        for (int i = 0; i < numRandom; i++) begin
            randomNormalPair(x, y);
            applyPair(x, y, expectedSum(x, y), "randomNormal");
        end
        for (int i = 0; i < numGap; i++) begin
            largeGapPair(x, y);
            applyPair(y, x, x, "largeGap");
        end
        // isolated pairs, then a back-to-back burst
        for (int i = 0; i < numSpaced; i++) begin
            randomNormalPair(x, y);
            applyPair(x, y, expectedSum(x, y), "spacedTiming");
            idleCycles(1);
        end
        for (int i = 0; i < numBurst; i++) begin
            randomNormalPair(x, y);
            applyPair(x, y, expectedSum(x, y), "burstOrder");
        end
        idleCycles(4);

        if (expQueue.size() != 0) begin
            $display("%0d results never arrived", expQueue.size());
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* floatAdder.f */
+incdir+include
src/floatFormatPkg.sv
src/addPathPkg.sv
src/floatUnpack.sv
src/alignOperands.sv
src/sumNormalize.sv
src/realRounding.sv
src/resultAdjust.sv
src/floatAdder.sv
testbench/floatAdderTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the floatAdder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f floatAdder.f --top-module floatAdderTb; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/VfloatAdderTb)
simStatus=$?
echo "$simOut"

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
